/* exu_pkg.sv */
package exu_pkg;

  localparam int XLEN          = 32;
  localparam int SHAMT_W       = $clog2(XLEN);
  localparam int MULDIV_CYCLES = 32;  // one result bit per iteration

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [3:0]      exc_op_t;
  typedef logic [4:0]      alu_op_t;
  typedef logic [2:0]      csr_op_t;
  typedef logic [4:0]      zimm_t;

  // instruction class from decode
  localparam exc_op_t EXCOP_NONE   = 4'd0;
  localparam exc_op_t EXCOP_LUI    = 4'd1;
  localparam exc_op_t EXCOP_AUIPC  = 4'd2;
  localparam exc_op_t EXCOP_JAL    = 4'd3;
  localparam exc_op_t EXCOP_JALR   = 4'd4;
  localparam exc_op_t EXCOP_BRANCH = 4'd5;
  localparam exc_op_t EXCOP_OPIMM  = 4'd6;
  localparam exc_op_t EXCOP_OPREG  = 4'd7;
  localparam exc_op_t EXCOP_CSR    = 4'd8;

  localparam alu_op_t ALU_ADD    = 5'd0;
  localparam alu_op_t ALU_SUB    = 5'd1;
  localparam alu_op_t ALU_SLL    = 5'd2;
  localparam alu_op_t ALU_SLT    = 5'd3;
  localparam alu_op_t ALU_SLTU   = 5'd4;
  localparam alu_op_t ALU_XOR    = 5'd5;
  localparam alu_op_t ALU_SRL    = 5'd6;
  localparam alu_op_t ALU_SRA    = 5'd7;
  localparam alu_op_t ALU_OR     = 5'd8;
  localparam alu_op_t ALU_AND    = 5'd9;
  localparam alu_op_t ALU_BEQ    = 5'd10;  // compare codes drive cmp only
  localparam alu_op_t ALU_BNE    = 5'd11;
  localparam alu_op_t ALU_BLT    = 5'd12;
  localparam alu_op_t ALU_BGE    = 5'd13;
  localparam alu_op_t ALU_BLTU   = 5'd14;
  localparam alu_op_t ALU_BGEU   = 5'd15;
  localparam alu_op_t ALU_MUL    = 5'd16;  // first code of the mul/div group
  localparam alu_op_t ALU_MULH   = 5'd17;
  localparam alu_op_t ALU_MULHSU = 5'd18;
  localparam alu_op_t ALU_MULHU  = 5'd19;
  localparam alu_op_t ALU_DIV    = 5'd20;
  localparam alu_op_t ALU_DIVU   = 5'd21;
  localparam alu_op_t ALU_REM    = 5'd22;
  localparam alu_op_t ALU_REMU   = 5'd23;

  // immediate form chosen by a separate flag
  localparam csr_op_t CSR_NONE = 3'd0;
  localparam csr_op_t CSR_RW   = 3'd1;
  localparam csr_op_t CSR_RS   = 3'd2;
  localparam csr_op_t CSR_RC   = 3'd3;

endpackage

/* muldiv_if.sv */
`timescale 1ns/1ps

interface muldiv_if;
  import exu_pkg::*;

  logic    req_valid;  // stage offers an operation
  logic    req_ready;  // unit is idle
  alu_op_t op;
  xlen_t   a;
  xlen_t   b;
  logic    rsp_valid;  // single-cycle pulse
  xlen_t   result;

  modport stage (
    output req_valid, op, a, b,
    input  req_ready, rsp_valid, result
  );

  modport unit (
    input  req_valid, op, a, b,
    output req_ready, rsp_valid, result
  );

endinterface

/* exu_alu.sv */
`timescale 1ns/1ps

module exu_alu (
  input  exu_pkg::alu_op_t alu_op_i,
  input  exu_pkg::xlen_t   a_i,
  input  exu_pkg::xlen_t   b_i,
  output exu_pkg::xlen_t   result_o,
  output logic             cmp_o
);
  import exu_pkg::*;

  logic               eq;
  logic               lt_s;
  logic               lt_u;
  logic [SHAMT_W-1:0] shamt;

  assign eq    = (a_i == b_i);
  assign lt_s  = ($signed(a_i) < $signed(b_i));
  assign lt_u  = (a_i < b_i);
  assign shamt = b_i[SHAMT_W-1:0];  // only the low bits count for shifts

  always_comb begin
    result_o = '0;
    cmp_o    = 1'b0;
    case (alu_op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SLT:  result_o = xlen_t'(lt_s);
      ALU_SLTU: result_o = xlen_t'(lt_u);
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_SRL:  result_o = a_i >> shamt;
      ALU_SRA:  result_o = xlen_t'($signed(a_i) >>> shamt);
      ALU_OR:   result_o = a_i | b_i;
      ALU_AND:  result_o = a_i & b_i;
      ALU_BEQ:  cmp_o = eq;
      ALU_BNE:  cmp_o = ~eq;
      ALU_BLT:  cmp_o = lt_s;
      ALU_BGE:  cmp_o = ~lt_s;
      ALU_BLTU: cmp_o = lt_u;
      ALU_BGEU: cmp_o = ~lt_u;
      default: begin
        // mul/div codes are handled by the iterative unit
        result_o = '0;
      end
    endcase
  end

endmodule

/* exu_muldiv.sv */
`timescale 1ns/1ps

module exu_muldiv (
  input  logic   clk,
  input  logic   rst_n_i,
  muldiv_if.unit bus
);
  import exu_pkg::*;

  localparam int CNT_W = $clog2(MULDIV_CYCLES);

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } state_e;

  state_e           state_q;
  logic [CNT_W-1:0] cnt_q;
  alu_op_t          op_q;
  xlen_t            hi_q;       // product high half or partial remainder
  xlen_t            lo_q;       // multiplier / dividend, shifts into product low or quotient
  xlen_t            opnd_q;     // multiplicand or divisor magnitude
  logic             neg_q;      // product or quotient needs negation
  logic             rem_neg_q;  // remainder follows dividend sign
  logic             dbz_q;

  logic                is_mul_req;
  logic                is_mul_q;
  logic                a_neg;
  logic                b_neg;
  xlen_t               a_mag;
  xlen_t               b_mag;
  logic [XLEN:0]       mul_sum;
  logic [XLEN:0]       div_shift;
  logic                div_ge;
  logic [XLEN:0]       div_rem;
  logic [2*XLEN-1:0]   prod_fix;
  xlen_t               quo_fix;
  xlen_t               rem_fix;

  // operand magnitudes at request time
  always_comb begin
    is_mul_req = bus.op inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU};
    a_neg      = (bus.op inside {ALU_MULH, ALU_MULHSU, ALU_DIV, ALU_REM}) & bus.a[XLEN-1];
    b_neg      = (bus.op inside {ALU_MULH, ALU_DIV, ALU_REM}) & bus.b[XLEN-1];
    a_mag      = a_neg ? -bus.a : bus.a;
    b_mag      = b_neg ? -bus.b : bus.b;
  end

  assign is_mul_q = op_q inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU};

  // one shift-add or one restoring step per cycle
  assign mul_sum   = {1'b0, hi_q} + (lo_q[0] ? {1'b0, opnd_q} : '0);
  assign div_shift = {hi_q, lo_q[XLEN-1]};
  assign div_ge    = (div_shift >= {1'b0, opnd_q});
  assign div_rem   = div_ge ? (div_shift - {1'b0, opnd_q}) : div_shift;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (bus.req_valid) begin
            state_q <= BUSY;
            cnt_q   <= '0;
          end
        end
        BUSY: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == CNT_W'(MULDIV_CYCLES - 1)) state_q <= DONE;
        end
        default: state_q <= IDLE;  // DONE lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (bus.req_valid && bus.req_ready) begin
      op_q      <= bus.op;
      hi_q      <= '0;
      lo_q      <= is_mul_req ? b_mag : a_mag;
      opnd_q    <= is_mul_req ? a_mag : b_mag;
      neg_q     <= a_neg ^ b_neg;
      rem_neg_q <= a_neg;
      dbz_q     <= ~is_mul_req & (bus.b == '0);
    end else if (state_q == BUSY) begin
      if (is_mul_q) begin
        hi_q <= mul_sum[XLEN:1];
        lo_q <= {mul_sum[0], lo_q[XLEN-1:1]};
      end else begin
        hi_q <= div_rem[XLEN-1:0];
        lo_q <= {lo_q[XLEN-2:0], div_ge};
      end
    end
  end

  // sign fix-up on the way out
  assign prod_fix = neg_q ? -{hi_q, lo_q} : {hi_q, lo_q};
  assign quo_fix  = dbz_q ? '1 : (neg_q ? -lo_q : lo_q);
  assign rem_fix  = rem_neg_q ? -hi_q : hi_q;  // gives the dividend back on div by zero

  always_comb begin
    case (op_q)
      ALU_MUL:                         bus.result = prod_fix[XLEN-1:0];
      ALU_MULH, ALU_MULHSU, ALU_MULHU: bus.result = prod_fix[2*XLEN-1:XLEN];
      ALU_DIV, ALU_DIVU:               bus.result = quo_fix;
      default:                         bus.result = rem_fix;
    endcase
  end

  assign bus.req_ready = (state_q == IDLE);
  assign bus.rsp_valid = (state_q == DONE);

endmodule

/* exu_branch.sv */
`timescale 1ns/1ps

module exu_branch (
  input  exu_pkg::exc_op_t exc_op_i,
  input  exu_pkg::xlen_t   pc_i,
  input  exu_pkg::xlen_t   rs1_i,
  input  exu_pkg::xlen_t   imm_i,
  input  logic             cmp_i,        // comparator outcome from the ALU
  input  logic             pdt_taken_i,  // predictor's guess
  output logic             taken_o,
  output logic             mispredict_o,
  output logic             is_branch_o,
  output exu_pkg::xlen_t   redirect_pc_o
);
  import exu_pkg::*;

  logic  op_branch;
  logic  op_jal;
  logic  op_jalr;
  xlen_t jalr_sum;
  xlen_t target;
  xlen_t fall_through;

  assign op_branch = (exc_op_i == EXCOP_BRANCH);
  assign op_jal    = (exc_op_i == EXCOP_JAL);
  assign op_jalr   = (exc_op_i == EXCOP_JALR);

  assign is_branch_o = op_branch | op_jal | op_jalr;
  assign taken_o     = (op_branch & cmp_i) | op_jal | op_jalr;

  // jalr drops bit 0 of the sum
  assign jalr_sum     = rs1_i + imm_i;
  assign target       = op_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : (pc_i + imm_i);
  assign fall_through = pc_i + xlen_t'(4);

  assign mispredict_o  = is_branch_o & (taken_o != pdt_taken_i);
  assign redirect_pc_o = taken_o ? target : fall_through;

endmodule

/* exu_csr.sv */
`timescale 1ns/1ps

module exu_csr (
  input  exu_pkg::csr_op_t csr_op_i,
  input  logic             imm_valid_i,
  input  exu_pkg::zimm_t   zimm_i,
  input  exu_pkg::xlen_t   rs1_i,
  input  exu_pkg::xlen_t   csr_old_i,
  output exu_pkg::xlen_t   csr_wdata_o,
  output logic             csr_we_o
);
  import exu_pkg::*;

  xlen_t src;

  assign src = imm_valid_i ? xlen_t'(zimm_i) : rs1_i;  // zimm is zero-extended

  always_comb begin
    csr_wdata_o = csr_old_i;
    csr_we_o    = 1'b0;
    case (csr_op_i)
      CSR_RW: begin
        csr_wdata_o = src;
        csr_we_o    = 1'b1;
      end
      CSR_RS: begin
        csr_wdata_o = csr_old_i | src;
        csr_we_o    = |src;  // no write for a zero mask
      end
      CSR_RC: begin
        csr_wdata_o = csr_old_i & ~src;
        csr_we_o    = |src;
      end
      default: csr_we_o = 1'b0;
    endcase
  end

endmodule

/* exu.sv */
`timescale 1ns/1ps

module exu (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               in_valid_i,
  output logic               in_ready_o,
  input  exu_pkg::xlen_t     pc_i,
  input  exu_pkg::exc_op_t   exc_op_i,
  input  exu_pkg::alu_op_t   alu_op_i,
  input  exu_pkg::reg_idx_t  rd_idx_i,
  input  exu_pkg::xlen_t     rs1_i,
  input  exu_pkg::xlen_t     rs2_i,
  input  exu_pkg::xlen_t     imm_i,
  input  exu_pkg::csr_op_t   csr_op_i,
  input  exu_pkg::xlen_t     csr_old_i,
  input  logic               csr_imm_valid_i,
  input  exu_pkg::zimm_t     zimm_i,
  input  logic               pdt_taken_i,
  output logic               out_valid_o,
  input  logic               out_ready_i,
  output exu_pkg::reg_idx_t  rd_idx_o,
  output exu_pkg::xlen_t     result_o,
  output logic               csr_we_o,
  output exu_pkg::xlen_t     csr_wdata_o,
  output logic               redirect_valid_o,
  output exu_pkg::xlen_t     redirect_pc_o,
  output logic               bpu_valid_o,
  output logic               branch_taken_o,
  output logic               pdt_correct_o
);
  import exu_pkg::*;

  muldiv_if md_bus ();

  alu_op_t  alu_op;
  xlen_t    alu_a;
  xlen_t    alu_b;
  xlen_t    alu_res;
  logic     alu_cmp;
  logic     taken;
  logic     mispredict;
  logic     is_branch;
  xlen_t    redirect_pc;
  xlen_t    csr_wdata;
  logic     csr_we;
  xlen_t    pc_plus4;
  xlen_t    ex_result;
  logic     is_md;
  logic     accept;
  logic     load_ex;
  reg_idx_t md_rd_q;  // destination of the instruction inside the mul/div unit

  // operand select by instruction class
  always_comb begin
    alu_a  = '0;
    alu_b  = '0;
    alu_op = alu_op_i;
    case (exc_op_i)
      EXCOP_OPREG, EXCOP_BRANCH: begin
        alu_a = rs1_i;
        alu_b = rs2_i;
      end
      EXCOP_OPIMM: begin
        alu_a = rs1_i;
        alu_b = imm_i;
      end
      EXCOP_LUI: begin
        alu_b  = imm_i;   // 0 + imm
        alu_op = ALU_ADD;
      end
      EXCOP_AUIPC: begin
        alu_a  = pc_i;
        alu_b  = imm_i;
        alu_op = ALU_ADD;
      end
      default: alu_op = alu_op_i;
    endcase
  end

  exu_alu u_alu (
    .alu_op_i (alu_op),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .result_o (alu_res),
    .cmp_o    (alu_cmp)
  );

  exu_branch u_branch (
    .exc_op_i      (exc_op_i),
    .pc_i          (pc_i),
    .rs1_i         (rs1_i),
    .imm_i         (imm_i),
    .cmp_i         (alu_cmp),
    .pdt_taken_i   (pdt_taken_i),
    .taken_o       (taken),
    .mispredict_o  (mispredict),
    .is_branch_o   (is_branch),
    .redirect_pc_o (redirect_pc)
  );

  exu_csr u_csr (
    .csr_op_i    (csr_op_i),
    .imm_valid_i (csr_imm_valid_i),
    .zimm_i      (zimm_i),
    .rs1_i       (rs1_i),
    .csr_old_i   (csr_old_i),
    .csr_wdata_o (csr_wdata),
    .csr_we_o    (csr_we)
  );

  exu_muldiv u_muldiv (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .bus     (md_bus.unit)
  );

  assign pc_plus4 = pc_i + xlen_t'(4);
  assign is_md    = (exc_op_i == EXCOP_OPREG) && (alu_op_i >= ALU_MUL);

  always_comb begin
    case (exc_op_i)
      EXCOP_JAL, EXCOP_JALR: ex_result = pc_plus4;   // link address
      EXCOP_CSR:             ex_result = csr_old_i;
      default:               ex_result = alu_res;
    endcase
  end

  // stage handshake; output reg is always empty when a mul/div result returns
  assign in_ready_o = (!out_valid_o || out_ready_i) && md_bus.req_ready;
  assign accept     = in_valid_i && in_ready_o;
  assign load_ex    = accept && !is_md;

  assign md_bus.req_valid = accept && is_md;
  assign md_bus.op        = alu_op_i;
  assign md_bus.a         = rs1_i;
  assign md_bus.b         = rs2_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      out_valid_o      <= 1'b0;
      redirect_valid_o <= 1'b0;
      bpu_valid_o      <= 1'b0;
      csr_we_o         <= 1'b0;
    end else if (load_ex || md_bus.rsp_valid) begin
      out_valid_o      <= 1'b1;
      redirect_valid_o <= load_ex & mispredict;
      bpu_valid_o      <= load_ex & is_branch;
      csr_we_o         <= load_ex & (exc_op_i == EXCOP_CSR) & csr_we;
    end else if (out_ready_i) begin
      out_valid_o      <= 1'b0;  // drained, flags go with it
      redirect_valid_o <= 1'b0;
      bpu_valid_o      <= 1'b0;
      csr_we_o         <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (md_bus.req_valid) md_rd_q <= rd_idx_i;
    if (load_ex) begin
      rd_idx_o       <= rd_idx_i;
      result_o       <= ex_result;
      csr_wdata_o    <= csr_wdata;
      redirect_pc_o  <= redirect_pc;
      branch_taken_o <= taken;
      pdt_correct_o  <= ~mispredict;
    end else if (md_bus.rsp_valid) begin
      rd_idx_o       <= md_rd_q;
      result_o       <= md_bus.result;
      csr_wdata_o    <= '0;
      redirect_pc_o  <= '0;
      branch_taken_o <= 1'b0;
      pdt_correct_o  <= 1'b1;
    end
  end

endmodule

/* exu_top.sv */
`timescale 1ns/1ps

module exu_top (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               in_valid_i,
  output logic               in_ready_o,
  input  exu_pkg::xlen_t     pc_i,
  input  exu_pkg::exc_op_t   exc_op_i,
  input  exu_pkg::alu_op_t   alu_op_i,
  input  exu_pkg::reg_idx_t  rd_idx_i,
  input  exu_pkg::xlen_t     rs1_i,
  input  exu_pkg::xlen_t     rs2_i,
  input  exu_pkg::xlen_t     imm_i,
  input  exu_pkg::csr_op_t   csr_op_i,
  input  exu_pkg::xlen_t     csr_old_i,
  input  logic               csr_imm_valid_i,
  input  exu_pkg::zimm_t     zimm_i,
  input  logic               pdt_taken_i,
  output logic               out_valid_o,
  input  logic               out_ready_i,
  output exu_pkg::reg_idx_t  rd_idx_o,
  output exu_pkg::xlen_t     result_o,
  output logic               csr_we_o,
  output exu_pkg::xlen_t     csr_wdata_o,
  output logic               redirect_valid_o,
  output exu_pkg::xlen_t     redirect_pc_o,
  output logic               bpu_valid_o,
  output logic               branch_taken_o,
  output logic               pdt_correct_o
);

  exu u_exu (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .in_valid_i       (in_valid_i),
    .in_ready_o       (in_ready_o),
    .pc_i             (pc_i),
    .exc_op_i         (exc_op_i),
    .alu_op_i         (alu_op_i),
    .rd_idx_i         (rd_idx_i),
    .rs1_i            (rs1_i),
    .rs2_i            (rs2_i),
    .imm_i            (imm_i),
    .csr_op_i         (csr_op_i),
    .csr_old_i        (csr_old_i),
    .csr_imm_valid_i  (csr_imm_valid_i),
    .zimm_i           (zimm_i),
    .pdt_taken_i      (pdt_taken_i),
    .out_valid_o      (out_valid_o),
    .out_ready_i      (out_ready_i),
    .rd_idx_o         (rd_idx_o),
    .result_o         (result_o),
    .csr_we_o         (csr_we_o),
    .csr_wdata_o      (csr_wdata_o),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o),
    .bpu_valid_o      (bpu_valid_o),
    .branch_taken_o   (branch_taken_o),
    .pdt_correct_o    (pdt_correct_o)
  );

endmodule

/* exu_assert.sv */
`timescale 1ns/1ps

module exu_assert (
  input logic              clk,
  input logic              rst_n_i,
  input logic              out_valid_o,
  input logic              out_ready_i,
  input logic              redirect_valid_o,
  input logic              bpu_valid_o,
  input logic              csr_we_o,
  input exu_pkg::xlen_t    result_o,
  input exu_pkg::xlen_t    redirect_pc_o,
  input exu_pkg::xlen_t    csr_wdata_o,
  input exu_pkg::reg_idx_t rd_idx_o
);

  int fail_cnt = 0;

  // stalled output must not move
  hold_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(result_o) &&
      $stable(rd_idx_o) && $stable(redirect_valid_o) && $stable(redirect_pc_o) &&
      $stable(bpu_valid_o) && $stable(csr_we_o) && $stable(csr_wdata_o)))
    else begin
      $error("outputs changed while stalled");
      fail_cnt++;
    end

  redirect_needs_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
    redirect_valid_o |-> out_valid_o)
    else begin
      $error("redirect_valid without out_valid");
      fail_cnt++;
    end

  reset_clears_valid: assert property (@(posedge clk) !rst_n_i |=> !out_valid_o)
    else begin
      $error("out_valid high after reset");
      fail_cnt++;
    end

endmodule

bind exu exu_assert u_exu_assert (.*);

/* tb_exu.sv */
`timescale 1ns/1ps

module tb_exu;
  import exu_pkg::*;

  typedef struct {
    string    name;
    exc_op_t  exc;
    alu_op_t  op;
    reg_idx_t rd;
    xlen_t    pc;
    xlen_t    rs1;
    xlen_t    rs2;
    xlen_t    imm;
    csr_op_t  csr_op;
    logic     cimm;
    zimm_t    zimm;
    xlen_t    cold;
    logic     pdt;
    int       hold;     // cycles of back-pressure on the output
    logic     chk_res;
    xlen_t    res;
    logic     bpu;
    logic     taken;
    logic     redir;
    xlen_t    rpc;
    logic     corr;
    logic     we;
    xlen_t    wdata;
  } test_t;

  logic clk;
  logic rst_n_i;
  logic in_valid_i, in_ready_o, out_valid_o, out_ready_i;
  xlen_t pc_i, rs1_i, rs2_i, imm_i, csr_old_i;
  exc_op_t exc_op_i;
  alu_op_t alu_op_i;
  reg_idx_t rd_idx_i, rd_idx_o;
  csr_op_t csr_op_i;
  logic csr_imm_valid_i, pdt_taken_i;
  zimm_t zimm_i;
  xlen_t result_o, csr_wdata_o, redirect_pc_o;
  logic csr_we_o, redirect_valid_o, bpu_valid_o, branch_taken_o, pdt_correct_o;

  test_t tests[$];
  int    errors;
  int    failed_tests;
  int    test_err;
  int    assert_seen;
  int    cycles;
  int    limit;

  exu_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // run limit, set once the table is built
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout: the DUT stopped responding after %0d cycles", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic xlen_t alu_model(alu_op_t op, xlen_t a, xlen_t b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_SLL:  return a << b[4:0];
      ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      ALU_XOR:  return a ^ b;
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return $signed(a) >>> b[4:0];
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      default:  return '0;
    endcase
  endfunction

  function automatic logic cmp_model(alu_op_t op, xlen_t a, xlen_t b);
    case (op)
      ALU_BEQ:  return a == b;
      ALU_BNE:  return a != b;
      ALU_BLT:  return $signed(a) < $signed(b);
      ALU_BGE:  return $signed(a) >= $signed(b);
      ALU_BLTU: return a < b;
      default:  return a >= b;  // BGEU
    endcase
  endfunction

  function automatic xlen_t md_model(alu_op_t op, xlen_t a, xlen_t b);
    longint      sa;
    longint      sb;
    longint      p_ss;
    longint      p_su;
    logic [63:0] ua;
    logic [63:0] ub;
    logic [63:0] p_uu;
    sa   = $signed(a);
    sb   = $signed(b);
    ua   = {32'b0, a};
    ub   = {32'b0, b};
    p_ss = sa * sb;
    p_su = sa * longint'(ub);
    p_uu = ua * ub;
    case (op)
      ALU_MUL:    return p_ss[31:0];
      ALU_MULH:   return p_ss[63:32];
      ALU_MULHSU: return p_su[63:32];
      ALU_MULHU:  return p_uu[63:32];
      ALU_DIV:    return (b == 0) ? '1 : xlen_t'(sa / sb);
      ALU_DIVU:   return (b == 0) ? '1 : a / b;
      ALU_REM:    return (b == 0) ? a : xlen_t'(sa % sb);
      default:    return (b == 0) ? a : a % b;  // REMU
    endcase
  endfunction

  function automatic test_t expect_for(test_t t);
    xlen_t src;
    xlen_t tgt;
    t.chk_res = 1'b1;
    t.bpu     = t.exc inside {EXCOP_BRANCH, EXCOP_JAL, EXCOP_JALR};
    t.taken   = 1'b0;
    t.redir   = 1'b0;
    t.rpc     = '0;
    t.corr    = 1'b1;
    t.we      = 1'b0;
    t.wdata   = '0;
    src       = t.cimm ? xlen_t'(t.zimm) : t.rs1;
    case (t.exc)
      EXCOP_LUI:   t.res = t.imm;
      EXCOP_AUIPC: t.res = t.pc + t.imm;
      EXCOP_JAL, EXCOP_JALR: t.res = t.pc + 4;
      EXCOP_OPIMM: t.res = alu_model(t.op, t.rs1, t.imm);
      EXCOP_BRANCH: t.chk_res = 1'b0;  // no result defined for branches
      EXCOP_CSR: begin
        t.res = t.cold;
        case (t.csr_op)
          CSR_RW:  t.wdata = src;
          CSR_RS:  t.wdata = t.cold | src;
          default: t.wdata = t.cold & ~src;
        endcase
        t.we = (t.csr_op == CSR_RW) || (src != 0);  // set and clear skip a zero source
      end
      default: begin
        if (t.op inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
                         ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU})
          t.res = md_model(t.op, t.rs1, t.rs2);
        else
          t.res = alu_model(t.op, t.rs1, t.rs2);
      end
    endcase
    if (t.bpu) begin
      t.taken = (t.exc == EXCOP_BRANCH) ? cmp_model(t.op, t.rs1, t.rs2) : 1'b1;
      tgt     = (t.exc == EXCOP_JALR) ? ((t.rs1 + t.imm) & ~32'd1) : t.pc + t.imm;
      t.rpc   = t.taken ? tgt : t.pc + 4;
      t.redir = (t.taken != t.pdt);
      t.corr  = ~t.redir;
    end
    return t;
  endfunction

  function automatic test_t make_test(string name, exc_op_t exc, alu_op_t op,
                                      xlen_t rs1, xlen_t rs2, xlen_t imm, logic pdt);
    test_t t;
    t.name   = name;
    t.exc    = exc;
    t.op     = op;
    t.rd     = reg_idx_t'($urandom);
    t.pc     = $urandom & ~32'd3;
    t.rs1    = rs1;
    t.rs2    = rs2;
    t.imm    = imm;
    t.csr_op = CSR_NONE;
    t.cimm   = 1'b0;
    t.zimm   = '0;
    t.cold   = $urandom;
    t.pdt    = pdt;
    t.hold   = 0;
    return expect_for(t);
  endfunction

  function automatic test_t csr_test(string name, csr_op_t cop, logic cimm,
                                     xlen_t rs1, zimm_t zimm);
    test_t t;
    t        = make_test(name, EXCOP_CSR, ALU_ADD, rs1, 0, 0, 0);
    t.csr_op = cop;
    t.cimm   = cimm;
    t.zimm   = zimm;
    return expect_for(t);
  endfunction

  function automatic logic [106:0] output_snapshot();
    return {out_valid_o, rd_idx_o, result_o, csr_we_o, csr_wdata_o, redirect_valid_o,
            redirect_pc_o, bpu_valid_o, branch_taken_o, pdt_correct_o};
  endfunction

  task automatic check_val(string test, string field, xlen_t exp, xlen_t got);
    assert (got === exp) else begin
      $display("Error %s %s: expected %h, actual %h", test, field, exp, got);
      errors++;
      test_err++;
    end
  endtask

  task automatic collect_assert_fails();
    int n;
    n           = uut.u_exu.u_exu_assert.fail_cnt - assert_seen;
    assert_seen = uut.u_exu.u_exu_assert.fail_cnt;
    errors      += n;
    test_err    += n;
  endtask

  task automatic drive(test_t t);
    in_valid_i      <= 1'b1;
    pc_i            <= t.pc;
    exc_op_i        <= t.exc;
    alu_op_i        <= t.op;
    rd_idx_i        <= t.rd;
    rs1_i           <= t.rs1;
    rs2_i           <= t.rs2;
    imm_i           <= t.imm;
    csr_op_i        <= t.csr_op;
    csr_old_i       <= t.cold;
    csr_imm_valid_i <= t.cimm;
    zimm_i          <= t.zimm;
    pdt_taken_i     <= t.pdt;
  endtask

  task automatic check_outputs(test_t t);
    check_val(t.name, "rd", t.rd, rd_idx_o);
    if (t.chk_res) check_val(t.name, "result", t.res, result_o);
    check_val(t.name, "bpu_valid", t.bpu, bpu_valid_o);
    check_val(t.name, "redirect_valid", t.redir, redirect_valid_o);
    if (t.bpu) begin
      check_val(t.name, "taken", t.taken, branch_taken_o);
      check_val(t.name, "redirect_pc", t.rpc, redirect_pc_o);
      check_val(t.name, "pdt_correct", t.corr, pdt_correct_o);
    end
    check_val(t.name, "csr_we", t.we, csr_we_o);
    if (t.exc == EXCOP_CSR) check_val(t.name, "csr_wdata", t.wdata, csr_wdata_o);
  endtask

  task automatic apply_test(test_t t);
    logic [106:0] snap;
    logic         is_md;
    is_md = (t.exc == EXCOP_OPREG) && (t.op >= ALU_MUL);
    @(posedge clk);
    drive(t);
    if (t.hold > 0) out_ready_i <= 1'b0;
    @(negedge clk);
    while (!in_ready_o) @(negedge clk);
    @(posedge clk);
    in_valid_i <= 1'b0;
    @(negedge clk);
    while (!out_valid_o) begin
      assert (!(is_md && in_ready_o)) else begin
        $display("%s: in_ready_o went high while the mul/div unit was busy", t.name);
        errors++;
        test_err++;
      end
      @(negedge clk);
    end
    check_outputs(t);
    snap = output_snapshot();
    repeat (t.hold) begin
      @(negedge clk);
      assert (output_snapshot() === snap && !in_ready_o) else begin
        $display("%s: outputs changed or in_ready_o rose under back-pressure", t.name);
        errors++;
        test_err++;
      end
    end
    if (t.hold > 0) begin
      @(posedge clk);
      out_ready_i <= 1'b1;
    end
  endtask

  // back-to-back ALU ops, one result per cycle
  task automatic run_stream(int n);
    test_t s[$];
    for (int i = 0; i < n; i++)
      s.push_back(make_test($sformatf("stream_%0d", i), EXCOP_OPREG, alu_op_t'(i % 10),
                            $urandom, $urandom, 0, 0));
    @(posedge clk);
    drive(s[0]);
    for (int k = 1; k <= n; k++) begin
      @(posedge clk);
      if (k < n) drive(s[k]);
      else in_valid_i <= 1'b0;
      @(negedge clk);
      assert (out_valid_o && in_ready_o) else begin
        $display("stream: result %0d did not arrive on its cycle", k - 1);
        errors++;
        test_err++;
      end
      check_outputs(s[k-1]);
    end
  endtask

  initial begin
    test_t t;
    xlen_t rhs;
    int    seed_ret;
    seed_ret = $urandom(32'ha910_4040);
    cycles = 0;
    errors = 0;
    failed_tests = 0;
    assert_seen = 0;
    rst_n_i = 1'b0;
    in_valid_i = 1'b0;
    out_ready_i = 1'b1;
    pc_i = '0;
    exc_op_i = EXCOP_NONE;
    alu_op_i = ALU_ADD;
    rd_idx_i = '0;
    rs1_i = '0;
    rs2_i = '0;
    imm_i = '0;
    csr_op_i = CSR_NONE;
    csr_old_i = '0;
    csr_imm_valid_i = 1'b0;
    zimm_i = '0;
    pdt_taken_i = 1'b0;

    for (int op = 0; op < 10; op++) begin
      tests.push_back(make_test($sformatf("reg_op%0d", op), EXCOP_OPREG, alu_op_t'(op),
                                $urandom, $urandom, 0, 0));
      tests.push_back(make_test($sformatf("imm_op%0d", op), EXCOP_OPIMM, alu_op_t'(op),
                                $urandom, 0, $urandom, 0));
    end
    tests.push_back(make_test("lui", EXCOP_LUI, ALU_ADD, $urandom, 0, 32'hABCDE000, 0));
    tests.push_back(make_test("auipc", EXCOP_AUIPC, ALU_ADD, 0, 0, 32'h00012000, 0));
    for (int op = ALU_BEQ; op <= ALU_BGEU; op++)
      for (int k = 0; k < 6; k++) begin
        // rs2 equal to rs1, above it signed only, or above it both ways
        rhs = (k < 2) ? 32'hFFFF0010 : ((k < 4) ? 32'h00000020 : 32'hFFFF0020);
        t = make_test($sformatf("br_op%0d_%0d", op, k), EXCOP_BRANCH, alu_op_t'(op),
                      32'hFFFF0010, rhs, 32'h40, k[0]);
        tests.push_back(t);
      end
    tests.push_back(make_test("jal", EXCOP_JAL, ALU_ADD, 0, 0, 32'h100, 0));
    tests.push_back(make_test("jalr", EXCOP_JALR, ALU_ADD, 32'h1000, 0, 32'h35, 1));
    for (int op = ALU_MUL; op <= ALU_REMU; op++) begin
      tests.push_back(make_test($sformatf("md_op%0d_rand", op), EXCOP_OPREG, alu_op_t'(op),
                                $urandom, $urandom, 0, 0));
      tests.push_back(make_test($sformatf("md_op%0d_neg", op), EXCOP_OPREG, alu_op_t'(op),
                                -32'sd77, -32'sd5, 0, 0));
      tests.push_back(make_test($sformatf("md_op%0d_dbz", op), EXCOP_OPREG, alu_op_t'(op),
                                -32'sd1234, 0, 0, 0));
    end
    tests.push_back(csr_test("csrrw", CSR_RW, 0, $urandom, 0));
    tests.push_back(csr_test("csrrs", CSR_RS, 0, $urandom, 0));
    tests.push_back(csr_test("csrrc", CSR_RC, 0, $urandom, 0));
    tests.push_back(csr_test("csrrwi", CSR_RW, 1, 0, 5'd9));
    tests.push_back(csr_test("csrrsi", CSR_RS, 1, 0, 5'd17));
    tests.push_back(csr_test("csrrci", CSR_RC, 1, 0, 5'd3));
    tests.push_back(csr_test("csrrs_zero", CSR_RS, 0, 0, 0));
    tests.push_back(csr_test("csrrci_zero", CSR_RC, 1, 0, 0));
    t = make_test("hold_alu", EXCOP_OPREG, ALU_XOR, $urandom, $urandom, 0, 0);
    t.hold = 5;
    tests.push_back(t);
    t = make_test("hold_mul", EXCOP_OPREG, ALU_MULH, $urandom, $urandom, 0, 0);
    t.hold = 3;
    tests.push_back(t);
    limit = (tests.size() + 1) * (MULDIV_CYCLES + 10);

    repeat (3) @(posedge clk);
    rst_n_i <= 1'b1;

    foreach (tests[i]) begin
      test_err = 0;
      apply_test(tests[i]);
      collect_assert_fails();
      $display("test %s: %s", tests[i].name, (test_err == 0) ? "ok" : "failed");
      if (test_err != 0) failed_tests++;
    end
    test_err = 0;
    run_stream(4);
    collect_assert_fails();
    $display("test stream: %s", (test_err == 0) ? "ok" : "failed");
    if (test_err != 0) failed_tests++;

    $display("tests run: %0d, failed: %0d, errors: %0d", tests.size() + 1, failed_tests,
             errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* filelist.f */
exu_pkg.sv
muldiv_if.sv
exu_alu.sv
exu_muldiv.sv
exu_branch.sv
exu_csr.sv
exu.sv
exu_top.sv
exu_assert.sv
tb_exu.sv

/* Bender.yml */
package:
  name: exu

sources:
  - exu_pkg.sv
  - muldiv_if.sv
  - exu_alu.sv
  - exu_muldiv.sv
  - exu_branch.sv
  - exu_csr.sv
  - exu.sv
  - exu_top.sv
  - target: test
    files:
      - exu_assert.sv
      - tb_exu.sv
